//--- logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// width of a data word and of the immediate.
`define DATA_LEN 32

// width of an architectural register number.
`define REG_SEL_LEN 5

// APB byte address width that reaches the three word registers.
`define APB_ADDR_LEN 4

`endif

//--- logic/rv_isa_pkg.sv
`default_nettype none

`include "decode_config.svh"

package rv_isa_pkg;

    typedef logic [31:0]               insn_t;
    typedef logic [`DATA_LEN-1:0]      data_t;
    typedef logic [`REG_SEL_LEN-1:0]   reg_sel_t;

    // major opcodes in bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_MISC_MEM = 7'b0001111
    } opcode_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;  // plain ALU and shift forms.
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB and SRA.
    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension.

endpackage

`default_nettype wire

//--- logic/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    typedef logic [2:0] imm_type_t;
    localparam imm_type_t IMM_NONE = 3'd0;  // zero so a cleared entry carries no immediate.
    localparam imm_type_t IMM_I    = 3'd1;
    localparam imm_type_t IMM_S    = 3'd2;
    localparam imm_type_t IMM_B    = 3'd3;
    localparam imm_type_t IMM_U    = 3'd4;
    localparam imm_type_t IMM_J    = 3'd5;

    typedef logic [1:0] src_a_sel_t;
    localparam src_a_sel_t SRC_A_RS1  = 2'd0;
    localparam src_a_sel_t SRC_A_PC   = 2'd1;
    localparam src_a_sel_t SRC_A_ZERO = 2'd2;

    typedef logic [1:0] src_b_sel_t;
    localparam src_b_sel_t SRC_B_RS2  = 2'd0;
    localparam src_b_sel_t SRC_B_IMM  = 2'd1;
    localparam src_b_sel_t SRC_B_FOUR = 2'd2;

    // register forms use {funct7[5], funct3} directly as the code.
    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_GE   = 4'b1001;
    localparam alu_op_t ALU_EQ   = 4'b1010;
    localparam alu_op_t ALU_NE   = 4'b1011;
    localparam alu_op_t ALU_LT   = 4'b1100;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_LTU  = 4'b1110;
    localparam alu_op_t ALU_GEU  = 4'b1111;

    typedef logic [1:0] rs_ent_t;
    localparam rs_ent_t RS_ENT_ALU    = 2'd0;
    localparam rs_ent_t RS_ENT_MUL    = 2'd1;
    localparam rs_ent_t RS_ENT_LDST   = 2'd2;
    localparam rs_ent_t RS_ENT_BRANCH = 2'd3;

    typedef logic mem_type_t;
    localparam mem_type_t MEM_LOAD  = 1'b0;
    localparam mem_type_t MEM_STORE = 1'b1;

    typedef logic md_op_t;
    localparam md_op_t MD_OP_MUL = 1'b0;
    localparam md_op_t MD_OP_DIV = 1'b1;

    typedef logic [1:0] md_out_sel_t;
    localparam md_out_sel_t MD_OUT_LO  = 2'd0;
    localparam md_out_sel_t MD_OUT_HI  = 2'd1;
    localparam md_out_sel_t MD_OUT_REM = 2'd2;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  rv_isa_pkg::insn_t            inst_i,
    input  logic                         m_ext_en_i,
    output decode_ctrl_pkg::imm_type_t   imm_type_o,
    output rv_isa_pkg::reg_sel_t         rs1_o,
    output rv_isa_pkg::reg_sel_t         rs2_o,
    output rv_isa_pkg::reg_sel_t         rd_o,
    output decode_ctrl_pkg::src_a_sel_t  src_a_sel_o,
    output decode_ctrl_pkg::src_b_sel_t  src_b_sel_o,
    output logic                         wr_reg_o,
    output logic                         uses_rs1_o,
    output logic                         uses_rs2_o,
    output logic                         illegal_o,
    output decode_ctrl_pkg::alu_op_t     alu_op_o,
    output decode_ctrl_pkg::rs_ent_t     rs_ent_o,
    output logic [2:0]                   dmem_size_o,
    output decode_ctrl_pkg::mem_type_t   dmem_type_o,
    output decode_ctrl_pkg::md_op_t      md_op_o,
    output logic                         md_a_signed_o,
    output logic                         md_b_signed_o,
    output decode_ctrl_pkg::md_out_sel_t md_out_sel_o
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wr_en;  // the class writes rd if the encoding is legal.

    assign opcode      = opcode_e'(inst_i[6:0]);
    assign funct3      = inst_i[14:12];
    assign funct7      = inst_i[31:25];
    assign rs1_o       = inst_i[19:15];
    assign rs2_o       = inst_i[24:20];
    assign rd_o        = inst_i[11:7];
    assign dmem_size_o = funct3;  // byte, half or word with the sign bit in bit 2.
    assign wr_reg_o    = wr_en && !illegal_o && (rd_o != '0);

    always_comb begin
        imm_type_o    = IMM_I;
        src_a_sel_o   = SRC_A_RS1;
        src_b_sel_o   = SRC_B_IMM;
        wr_en         = 1'b0;
        uses_rs1_o    = 1'b1;
        uses_rs2_o    = 1'b0;
        illegal_o     = 1'b0;
        alu_op_o      = ALU_ADD;
        rs_ent_o      = RS_ENT_ALU;
        dmem_type_o   = MEM_LOAD;
        md_op_o       = MD_OP_MUL;
        md_a_signed_o = 1'b0;
        md_b_signed_o = 1'b0;
        md_out_sel_o  = MD_OUT_LO;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                imm_type_o  = IMM_U;
                src_a_sel_o = (opcode == OPC_LUI) ? SRC_A_ZERO : SRC_A_PC;
                uses_rs1_o  = 1'b0;
                wr_en       = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                imm_type_o  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                src_a_sel_o = SRC_A_PC;  // the ALU forms the link value pc + 4.
                src_b_sel_o = SRC_B_FOUR;
                uses_rs1_o  = (opcode == OPC_JALR);
                rs_ent_o    = RS_ENT_BRANCH;
                wr_en       = 1'b1;
                illegal_o   = (opcode == OPC_JALR) && (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_type_o  = IMM_B;
                src_b_sel_o = SRC_B_RS2;
                uses_rs2_o  = 1'b1;
                rs_ent_o    = RS_ENT_BRANCH;
                case (funct3)
                    3'b000:  alu_op_o = ALU_EQ;
                    3'b001:  alu_op_o = ALU_NE;
                    3'b100:  alu_op_o = ALU_LT;
                    3'b101:  alu_op_o = ALU_GE;
                    3'b110:  alu_op_o = ALU_LTU;
                    3'b111:  alu_op_o = ALU_GEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                rs_ent_o  = RS_ENT_LDST;
                wr_en     = 1'b1;
                illegal_o = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                imm_type_o  = IMM_S;
                uses_rs2_o  = 1'b1;
                rs_ent_o    = RS_ENT_LDST;
                dmem_type_o = MEM_STORE;
                illegal_o   = funct3[2] || (funct3 == 3'b011);
            end
            OPC_OP_IMM: begin
                wr_en    = 1'b1;
                alu_op_o = {1'b0, funct3};
                if (funct3 == 3'b001) begin
                    illegal_o = (funct7 != F7_BASE);
                end else if (funct3 == 3'b101) begin
                    alu_op_o  = {funct7[5], funct3};  // SRLI or SRAI.
                    illegal_o = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
            end
            OPC_OP: begin
                imm_type_o  = IMM_NONE;
                src_b_sel_o = SRC_B_RS2;
                uses_rs2_o  = 1'b1;
                wr_en       = 1'b1;
                if (funct7 == F7_MULDIV) begin
                    illegal_o     = !m_ext_en_i;
                    rs_ent_o      = RS_ENT_MUL;
                    md_op_o       = funct3[2] ? MD_OP_DIV : MD_OP_MUL;
                    md_a_signed_o = funct3[2] ? !funct3[0] : (funct3[1:0] != 2'b11);
                    md_b_signed_o = funct3[2] ? !funct3[0] : !funct3[1];
                    if (funct3[2])
                        md_out_sel_o = funct3[1] ? MD_OUT_REM : MD_OUT_LO;
                    else
                        md_out_sel_o = (funct3[1:0] == 2'b00) ? MD_OUT_LO : MD_OUT_HI;
                end else begin
                    alu_op_o  = {funct7[5], funct3};
                    illegal_o = !((funct7 == F7_BASE) ||
                                  ((funct7 == F7_ALT) && (funct3 == 3'b000 || funct3 == 3'b101)));
                end
            end
            OPC_MISC_MEM: begin
                // FENCE issues as a no-op in the ALU station.
                imm_type_o = IMM_NONE;
                uses_rs1_o = 1'b0;
                illegal_o  = (funct3 != 3'b000);
            end
            default: begin
                uses_rs1_o = 1'b0;
                illegal_o  = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/imm_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module imm_decoder (
    input  rv_isa_pkg::insn_t          inst_i,
    input  decode_ctrl_pkg::imm_type_t imm_type_i,
    output rv_isa_pkg::data_t          imm_o
);
    import decode_ctrl_pkg::*;

    logic sign;

    assign sign = inst_i[31];  // every format takes its sign from bit 31.

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{(`DATA_LEN-12){sign}}, inst_i[31:20]};
            IMM_S: imm_o = {{(`DATA_LEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            IMM_B: begin
                imm_o = {{(`DATA_LEN-13){sign}}, sign, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {inst_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{(`DATA_LEN-21){sign}}, sign, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  rv_isa_pkg::insn_t            inst_i,
    input  logic                         inst_valid_i,
    input  logic                         stall_dp_i,
    input  logic                         kill_id_i,
    input  logic                         m_ext_en_i,
    output logic                         valid_o,
    output rv_isa_pkg::data_t            imm_o,
    output decode_ctrl_pkg::imm_type_t   imm_type_o,
    output rv_isa_pkg::reg_sel_t         rs1_o,
    output rv_isa_pkg::reg_sel_t         rs2_o,
    output rv_isa_pkg::reg_sel_t         rd_o,
    output decode_ctrl_pkg::src_a_sel_t  src_a_sel_o,
    output decode_ctrl_pkg::src_b_sel_t  src_b_sel_o,
    output logic                         wr_reg_o,
    output logic                         uses_rs1_o,
    output logic                         uses_rs2_o,
    output logic                         illegal_o,
    output decode_ctrl_pkg::alu_op_t     alu_op_o,
    output decode_ctrl_pkg::rs_ent_t     rs_ent_o,
    output logic [2:0]                   dmem_size_o,
    output decode_ctrl_pkg::mem_type_t   dmem_type_o,
    output decode_ctrl_pkg::md_op_t      md_op_o,
    output logic                         md_a_signed_o,
    output logic                         md_b_signed_o,
    output decode_ctrl_pkg::md_out_sel_t md_out_sel_o,
    output logic                         load_valid_o,
    output logic                         load_illegal_o
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    data_t       dec_imm;
    imm_type_t   dec_imm_type;
    reg_sel_t    dec_rs1;
    reg_sel_t    dec_rs2;
    reg_sel_t    dec_rd;
    src_a_sel_t  dec_src_a_sel;
    src_b_sel_t  dec_src_b_sel;
    logic        dec_wr_reg;
    logic        dec_uses_rs1;
    logic        dec_uses_rs2;
    logic        dec_illegal;
    alu_op_t     dec_alu_op;
    rs_ent_t     dec_rs_ent;
    logic [2:0]  dec_dmem_size;
    mem_type_t   dec_dmem_type;
    md_op_t      dec_md_op;
    logic        dec_md_a_signed;
    logic        dec_md_b_signed;
    md_out_sel_t dec_md_out_sel;
    logic        clr;

    inst_decoder u_inst_decoder (
        .inst_i        (inst_i),
        .m_ext_en_i    (m_ext_en_i),
        .imm_type_o    (dec_imm_type),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .rd_o          (dec_rd),
        .src_a_sel_o   (dec_src_a_sel),
        .src_b_sel_o   (dec_src_b_sel),
        .wr_reg_o      (dec_wr_reg),
        .uses_rs1_o    (dec_uses_rs1),
        .uses_rs2_o    (dec_uses_rs2),
        .illegal_o     (dec_illegal),
        .alu_op_o      (dec_alu_op),
        .rs_ent_o      (dec_rs_ent),
        .dmem_size_o   (dec_dmem_size),
        .dmem_type_o   (dec_dmem_type),
        .md_op_o       (dec_md_op),
        .md_a_signed_o (dec_md_a_signed),
        .md_b_signed_o (dec_md_b_signed),
        .md_out_sel_o  (dec_md_out_sel)
    );

    imm_decoder u_imm_decoder (
        .inst_i     (inst_i),
        .imm_type_i (dec_imm_type),
        .imm_o      (dec_imm)
    );

    assign clr = rst_i || kill_id_i;  // kill wins over a dispatch stall.

    always_ff @(posedge clk_i) begin
        if (clr || !stall_dp_i) begin
            valid_o       <= clr ? 1'b0 : inst_valid_i;
            imm_o         <= clr ? '0 : dec_imm;
            imm_type_o    <= clr ? '0 : dec_imm_type;
            rs1_o         <= clr ? '0 : dec_rs1;
            rs2_o         <= clr ? '0 : dec_rs2;
            rd_o          <= clr ? '0 : dec_rd;
            src_a_sel_o   <= clr ? '0 : dec_src_a_sel;
            src_b_sel_o   <= clr ? '0 : dec_src_b_sel;
            wr_reg_o      <= clr ? 1'b0 : dec_wr_reg;
            uses_rs1_o    <= clr ? 1'b0 : dec_uses_rs1;
            uses_rs2_o    <= clr ? 1'b0 : dec_uses_rs2;
            illegal_o     <= clr ? 1'b0 : dec_illegal;
            alu_op_o      <= clr ? '0 : dec_alu_op;
            rs_ent_o      <= clr ? '0 : dec_rs_ent;
            dmem_size_o   <= clr ? '0 : dec_dmem_size;
            dmem_type_o   <= clr ? '0 : dec_dmem_type;
            md_op_o       <= clr ? '0 : dec_md_op;
            md_a_signed_o <= clr ? 1'b0 : dec_md_a_signed;
            md_b_signed_o <= clr ? 1'b0 : dec_md_b_signed;
            md_out_sel_o  <= clr ? '0 : dec_md_out_sel;
        end
    end

    // one pulse per valid entry written, so a held entry is counted once.
    always_ff @(posedge clk_i) begin
        if (clr || stall_dp_i) begin
            load_valid_o   <= 1'b0;
            load_illegal_o <= 1'b0;
        end else begin
            load_valid_o   <= inst_valid_i;
            load_illegal_o <= inst_valid_i && dec_illegal;
        end
    end

endmodule

`default_nettype wire

//--- logic/decode_csr_apb.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module decode_csr_apb (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`APB_ADDR_LEN-1:0] paddr_i,
    input  rv_isa_pkg::data_t        pwdata_i,
    output rv_isa_pkg::data_t        prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    input  logic                     load_valid_i,
    input  logic                     load_illegal_i,
    output logic                     m_ext_en_o
);
    import rv_isa_pkg::*;

    localparam logic [`APB_ADDR_LEN-1:0] ADDR_CTRL      = 'h0;
    localparam logic [`APB_ADDR_LEN-1:0] ADDR_DEC_COUNT = 'h4;
    localparam logic [`APB_ADDR_LEN-1:0] ADDR_ILL_COUNT = 'h8;

    logic       access;
    logic       wr;
    logic [1:0] cnt_inc;
    logic [1:0] cnt_clr;
    data_t      cnt_q [2];  // entry 0 counts decodes, entry 1 counts illegal ones.

    assign access   = psel_i && penable_i;
    assign wr       = access && pwrite_i;
    assign pready_o = 1'b1;  // no wait states.

    assign cnt_inc = {load_illegal_i, load_valid_i};
    assign cnt_clr = {wr && (paddr_i == ADDR_ILL_COUNT), wr && (paddr_i == ADDR_DEC_COUNT)};

    always_ff @(posedge clk_i) begin
        if (rst_i)
            m_ext_en_o <= 1'b1;
        else if (wr && (paddr_i == ADDR_CTRL))
            m_ext_en_o <= pwdata_i[0];
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 2; i++) begin
            if (rst_i || cnt_clr[i])
                cnt_q[i] <= '0;
            else if (cnt_inc[i] && (cnt_q[i] != '1))
                cnt_q[i] <= cnt_q[i] + 1'b1;  // saturates at all ones.
        end
    end

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (paddr_i)
            ADDR_CTRL:      prdata_o[0] = m_ext_en_o;
            ADDR_DEC_COUNT: prdata_o = cnt_q[0];
            ADDR_ILL_COUNT: prdata_o = cnt_q[1];
            default:        pslverr_o = access;  // unmapped address.
        endcase
    end

endmodule

`default_nettype wire

//--- logic/decode_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module decode_unit_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  rv_isa_pkg::insn_t            inst_i,
    input  logic                         inst_valid_i,
    input  logic                         stall_dp_i,
    input  logic                         kill_id_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [`APB_ADDR_LEN-1:0]     paddr_i,
    input  rv_isa_pkg::data_t            pwdata_i,
    output rv_isa_pkg::data_t            prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output logic                         valid_o,
    output rv_isa_pkg::data_t            imm_o,
    output decode_ctrl_pkg::imm_type_t   imm_type_o,
    output rv_isa_pkg::reg_sel_t         rs1_o,
    output rv_isa_pkg::reg_sel_t         rs2_o,
    output rv_isa_pkg::reg_sel_t         rd_o,
    output decode_ctrl_pkg::src_a_sel_t  src_a_sel_o,
    output decode_ctrl_pkg::src_b_sel_t  src_b_sel_o,
    output logic                         wr_reg_o,
    output logic                         uses_rs1_o,
    output logic                         uses_rs2_o,
    output logic                         illegal_o,
    output decode_ctrl_pkg::alu_op_t     alu_op_o,
    output decode_ctrl_pkg::rs_ent_t     rs_ent_o,
    output logic [2:0]                   dmem_size_o,
    output decode_ctrl_pkg::mem_type_t   dmem_type_o,
    output decode_ctrl_pkg::md_op_t      md_op_o,
    output logic                         md_a_signed_o,
    output logic                         md_b_signed_o,
    output decode_ctrl_pkg::md_out_sel_t md_out_sel_o
);
    logic m_ext_en;
    logic load_valid;
    logic load_illegal;

    // all other ports share their names with the top level.
    id_stage u_id_stage (
        .*,
        .m_ext_en_i     (m_ext_en),
        .load_valid_o   (load_valid),
        .load_illegal_o (load_illegal)
    );

    decode_csr_apb u_decode_csr_apb (
        .*,
        .load_valid_i   (load_valid),
        .load_illegal_i (load_illegal),
        .m_ext_en_o     (m_ext_en)
    );

endmodule

`default_nettype wire

//--- sim/decode_unit_chk.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit_chk (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     stall_i,
    input  logic                     kill_i,
    input  logic                     valid_i,
    input  rv_isa_pkg::data_t        imm_i,
    input  rv_isa_pkg::reg_sel_t     rd_i,
    input  decode_ctrl_pkg::alu_op_t alu_op_i,
    input  decode_ctrl_pkg::rs_ent_t rs_ent_i,
    input  logic                     illegal_i,
    input  logic                     wr_reg_i,
    input  logic                     load_valid_i,
    input  logic                     load_illegal_i
);
    int fail_cnt = 0;  // number of failed assertions.

    clear_drops_valid: assert property (@(posedge clk_i) (rst_i || kill_i) |=> !valid_i)
        else begin
            fail_cnt++;
            $error("valid_o high after a reset or kill edge");
        end

    stall_holds_entry: assert property (@(posedge clk_i)
        (stall_i && !rst_i && !kill_i) |=>
        $stable({valid_i, imm_i, rd_i, alu_op_i, rs_ent_i, illegal_i, wr_reg_i}))
        else begin
            fail_cnt++;
            $error("decode outputs changed across a stalled edge");
        end

    illegal_needs_valid: assert property (@(posedge clk_i) load_illegal_i |-> load_valid_i)
        else begin
            fail_cnt++;
            $error("load_illegal_o without load_valid_o");
        end

endmodule

bind id_stage decode_unit_chk u_chk (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .stall_i        (stall_dp_i),
    .kill_i         (kill_id_i),
    .valid_i        (valid_o),
    .imm_i          (imm_o),
    .rd_i           (rd_o),
    .alu_op_i       (alu_op_o),
    .rs_ent_i       (rs_ent_o),
    .illegal_i      (illegal_o),
    .wr_reg_i       (wr_reg_o),
    .load_valid_i   (load_valid_o),
    .load_illegal_i (load_illegal_o)
);

`default_nettype wire

//--- sim/decode_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_config.svh"

module decode_unit_tb;
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam logic [`APB_ADDR_LEN-1:0] CTRL_ADDR   = 4'h0;
    localparam logic [`APB_ADDR_LEN-1:0] DEC_ADDR    = 4'h4;
    localparam logic [`APB_ADDR_LEN-1:0] ILL_ADDR    = 4'h8;
    localparam logic [`APB_ADDR_LEN-1:0] UNMAP_ADDR  = 4'hc;
    localparam int                       STALL_ROUNDS = 3;

    logic clk_i = 1'b0;
    logic rst_i, inst_valid_i, stall_dp_i, kill_id_i;
    insn_t inst_i;
    logic psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
    logic [`APB_ADDR_LEN-1:0] paddr_i;
    data_t pwdata_i, prdata_o, imm_o;
    imm_type_t imm_type_o;
    reg_sel_t rs1_o, rs2_o, rd_o;
    src_a_sel_t src_a_sel_o;
    src_b_sel_t src_b_sel_o;
    logic valid_o, wr_reg_o, uses_rs1_o, uses_rs2_o, illegal_o;
    alu_op_t alu_op_o;
    rs_ent_t rs_ent_o;
    logic [2:0] dmem_size_o;
    mem_type_t dmem_type_o;
    md_op_t md_op_o;
    logic md_a_signed_o, md_b_signed_o;
    md_out_sel_t md_out_sel_o;

    // the stimulus table keeps one queue per column.
    string t_name[$];
    insn_t t_inst[$];
    bit t_m_ext[$], t_ill[$], t_wr[$];
    reg_sel_t t_rd[$], t_rs1[$], t_rs2[$];
    data_t t_imm[$];
    alu_op_t t_alu[$];
    rs_ent_t t_rs_ent[$];
    src_a_sel_t t_src_a[$];
    src_b_sel_t t_src_b[$];

    int exp_dec = 0;
    int exp_ill = 0;
    int cycle_cnt = 0;
    int timeout_limit = 200;
    bit cur_m_ext = 1'b1;  // CTRL bit 0 after reset.

    decode_unit_top DUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Test FAILED");
            $fatal(1, "timeout: the run did not finish within %0d cycles", timeout_limit);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "check failed in %s", name);
        end
    endtask

    task automatic add_entry(input string name, input insn_t inst, input bit m_ext,
                             input bit ill, input bit wr, input reg_sel_t rd,
                             input reg_sel_t rs1, input reg_sel_t rs2, input data_t imm,
                             input alu_op_t alu, input rs_ent_t rs_ent,
                             input src_a_sel_t src_a, input src_b_sel_t src_b);
        t_name.push_back(name);
        t_inst.push_back(inst);
        t_m_ext.push_back(m_ext);
        t_ill.push_back(ill);
        t_wr.push_back(wr);
        t_rd.push_back(rd);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_imm.push_back(imm);
        t_alu.push_back(alu);
        t_rs_ent.push_back(rs_ent);
        t_src_a.push_back(src_a);
        t_src_b.push_back(src_b);
    endtask

    task automatic build_table();
        add_entry("add", 32'h002081b3, 1, 0, 1, 5'd3, 5'd1, 5'd2,
                  32'h0, ALU_ADD, RS_ENT_ALU, SRC_A_RS1, SRC_B_RS2);
        add_entry("sub", 32'h407302b3, 1, 0, 1, 5'd5, 5'd6, 5'd7,
                  32'h0, ALU_SUB, RS_ENT_ALU, SRC_A_RS1, SRC_B_RS2);
        add_entry("sra", 32'h40a4d433, 1, 0, 1, 5'd8, 5'd9, 5'd10,
                  32'h0, ALU_SRA, RS_ENT_ALU, SRC_A_RS1, SRC_B_RS2);
        add_entry("addi", 32'hffb10093, 1, 0, 1, 5'd1, 5'd2, 5'd27,
                  32'hfffffffb, ALU_ADD, RS_ENT_ALU, SRC_A_RS1, SRC_B_IMM);
        add_entry("srai", 32'h40325213, 1, 0, 1, 5'd4, 5'd4, 5'd3,
                  32'h00000403, ALU_SRA, RS_ENT_ALU, SRC_A_RS1, SRC_B_IMM);
        add_entry("lui", 32'h12345537, 1, 0, 1, 5'd10, 5'd8, 5'd3,
                  32'h12345000, ALU_ADD, RS_ENT_ALU, SRC_A_ZERO, SRC_B_IMM);
        add_entry("auipc", 32'hfffff097, 1, 0, 1, 5'd1, 5'd31, 5'd31,
                  32'hfffff000, ALU_ADD, RS_ENT_ALU, SRC_A_PC, SRC_B_IMM);
        add_entry("jal", 32'h008000ef, 1, 0, 1, 5'd1, 5'd0, 5'd8,
                  32'h8, ALU_ADD, RS_ENT_BRANCH, SRC_A_PC, SRC_B_FOUR);
        add_entry("jalr", 32'h00008067, 1, 0, 0, 5'd0, 5'd1, 5'd0,
                  32'h0, ALU_ADD, RS_ENT_BRANCH, SRC_A_PC, SRC_B_FOUR);
        add_entry("bne", 32'hfe209ee3, 1, 0, 0, 5'd29, 5'd1, 5'd2,
                  32'hfffffffc, ALU_NE, RS_ENT_BRANCH, SRC_A_RS1, SRC_B_RS2);
        add_entry("bgeu", 32'h0041f863, 1, 0, 0, 5'd16, 5'd3, 5'd4,
                  32'h10, ALU_GEU, RS_ENT_BRANCH, SRC_A_RS1, SRC_B_RS2);
        add_entry("lw", 32'h00c12283, 1, 0, 1, 5'd5, 5'd2, 5'd12,
                  32'hc, ALU_ADD, RS_ENT_LDST, SRC_A_RS1, SRC_B_IMM);
        add_entry("sw", 32'h00942a23, 1, 0, 0, 5'd20, 5'd8, 5'd9,
                  32'h14, ALU_ADD, RS_ENT_LDST, SRC_A_RS1, SRC_B_IMM);
        add_entry("mul", 32'h022081b3, 1, 0, 1, 5'd3, 5'd1, 5'd2,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
        add_entry("divu", 32'h027352b3, 1, 0, 1, 5'd5, 5'd6, 5'd7,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
        add_entry("rem", 32'h02a4e433, 1, 0, 1, 5'd8, 5'd9, 5'd10,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
        add_entry("bad_opcode", 32'h0000000b, 1, 1, 0, 5'd0, 5'd0, 5'd0,
                  32'h0, ALU_ADD, RS_ENT_ALU, SRC_A_RS1, SRC_B_IMM);
        add_entry("bad_funct7", 32'h202081b3, 1, 1, 0, 5'd3, 5'd1, 5'd2,
                  32'h0, ALU_ADD, RS_ENT_ALU, SRC_A_RS1, SRC_B_RS2);
        add_entry("mul_off", 32'h022081b3, 0, 1, 0, 5'd3, 5'd1, 5'd2,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
        add_entry("divu_off", 32'h027352b3, 0, 1, 0, 5'd5, 5'd6, 5'd7,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
        add_entry("mul_on", 32'h022081b3, 1, 0, 1, 5'd3, 5'd1, 5'd2,
                  32'h0, ALU_ADD, RS_ENT_MUL, SRC_A_RS1, SRC_B_RS2);
    endtask

    // the APB tasks start and end on a falling edge.
    task automatic apb_write(input logic [`APB_ADDR_LEN-1:0] addr, input data_t data);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk_i);
        penable_i = 1'b1;  // access phase ends at the next rising edge.
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_LEN-1:0] addr, output data_t data,
                            output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;  // sample in the middle of the access phase.
        check_value("apb pready", 1, pready_o);
        data = prdata_o;
        err  = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic check_entry(input int i, input string tag);
        string n;
        n = {tag, t_name[i]};
        check_value({n, " valid"}, 1, valid_o);
        check_value({n, " illegal"}, t_ill[i], illegal_o);
        check_value({n, " wr_reg"}, t_wr[i], wr_reg_o);
        check_value({n, " rd"}, t_rd[i], rd_o);
        check_value({n, " rs1"}, t_rs1[i], rs1_o);
        check_value({n, " rs2"}, t_rs2[i], rs2_o);
        check_value({n, " imm"}, t_imm[i], imm_o);
        check_value({n, " alu_op"}, t_alu[i], alu_op_o);
        check_value({n, " rs_ent"}, t_rs_ent[i], rs_ent_o);
        check_value({n, " src_a"}, t_src_a[i], src_a_sel_o);
        check_value({n, " src_b"}, t_src_b[i], src_b_sel_o);
    endtask

    task automatic count_load(input int i);
        exp_dec++;
        if (t_ill[i])
            exp_ill++;
    endtask

    task automatic apply_entry(input int i);
        if (t_m_ext[i] != cur_m_ext) begin
            apb_write(CTRL_ADDR, {31'b0, t_m_ext[i]});
            cur_m_ext = t_m_ext[i];
        end
        inst_i       = t_inst[i];
        inst_valid_i = 1'b1;
        @(negedge clk_i);
        check_entry(i, "");
        count_load(i);
        inst_valid_i = 1'b0;
    endtask

    // entry a loads, then b waits behind a stall of random length.
    task automatic stall_test(input int a, input int b);
        int n;
        for (int r = 0; r < STALL_ROUNDS; r++) begin
            inst_i       = t_inst[a];
            inst_valid_i = 1'b1;
            @(negedge clk_i);
            check_entry(a, "stall ");
            count_load(a);
            inst_i     = t_inst[b];
            stall_dp_i = 1'b1;
            n = 1 + ($urandom % 6);
            repeat (n) begin
                @(negedge clk_i);
                check_entry(a, "stalled ");
            end
            stall_dp_i = 1'b0;
            @(negedge clk_i);
            check_entry(b, "unstall ");
            count_load(b);
            inst_valid_i = 1'b0;
        end
    endtask

    // a kill edge clears the entry whatever the input decodes to.
    task automatic kill_entry(input int i);
        string n;
        n = {"kill ", t_name[i]};
        inst_i       = t_inst[i];
        inst_valid_i = 1'b1;
        kill_id_i    = 1'b1;
        @(negedge clk_i);
        kill_id_i    = 1'b0;
        inst_valid_i = 1'b0;
        check_value({n, " valid"}, 0, valid_o);
        check_value({n, " imm"}, 0, imm_o);
        check_value({n, " ctrl"}, 0, {rd_o, rs1_o, rs2_o, alu_op_o, rs_ent_o, src_a_sel_o,
                                      src_b_sel_o, imm_type_o, wr_reg_o, illegal_o});
        check_value({n, " misc"}, 0, {uses_rs1_o, uses_rs2_o, dmem_size_o, dmem_type_o,
                                      md_op_o, md_a_signed_o, md_b_signed_o, md_out_sel_o});
    endtask

    initial begin
        data_t rd_data;
        logic  rd_err;
        void'($urandom(32'h7dba));
        rst_i        = 1'b1;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        stall_dp_i   = 1'b0;
        kill_id_i    = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        build_table();
        timeout_limit = 20 * t_name.size() + 200;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        check_value("reset valid", 0, valid_o);
        check_value("reset wr_reg", 0, wr_reg_o);
        check_value("reset illegal", 0, illegal_o);
        apb_read(CTRL_ADDR, rd_data, rd_err);
        check_value("reset m_ext_en", 1, rd_data);

        for (int i = 0; i < t_name.size(); i++)
            apply_entry(i);
        stall_test(0, 11);

        for (int i = 0; i < t_name.size(); i++)
            kill_entry(i);

        apb_read(DEC_ADDR, rd_data, rd_err);
        check_value("dec_count", exp_dec, rd_data);
        check_value("dec_count pslverr", 0, rd_err);
        apb_read(ILL_ADDR, rd_data, rd_err);
        check_value("ill_count", exp_ill, rd_data);
        apb_write(DEC_ADDR, '0);
        apb_write(ILL_ADDR, '0);
        apb_read(DEC_ADDR, rd_data, rd_err);
        check_value("dec_count cleared", 0, rd_data);
        apb_read(ILL_ADDR, rd_data, rd_err);
        check_value("ill_count cleared", 0, rd_data);
        apb_read(UNMAP_ADDR, rd_data, rd_err);
        check_value("unmapped pslverr", 1, rd_err);

        if (DUT.u_id_stage.u_chk.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "%0d assertion failures", DUT.u_id_stage.u_chk.fail_cnt);
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/decode_ctrl_pkg.sv
logic/inst_decoder.sv
logic/imm_decoder.sv
logic/id_stage.sv
logic/decode_csr_apb.sv
logic/decode_unit_top.sv
sim/decode_unit_chk.sv
sim/decode_unit_tb.sv
